//--- src/spi_mode_pkg.sv
package spi_mode_pkg;

    // Bus mode encoded as {cpol, cpha}
    typedef enum logic [1:0] {
        MODE0 = 2'b00,
        MODE1 = 2'b01,
        MODE2 = 2'b10,
        MODE3 = 2'b11
    } spi_mode_t;

    // Bits per transfer
    localparam int DEFAULT_DATA_WIDTH = 8;

    // clk cycles per sclk half-period
    localparam int DEFAULT_CLK_DIV = 4;

endpackage

//--- src/spi_fsm_pkg.sv
package spi_fsm_pkg;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        TRANSFER,
        FINISH
    } spi_state_t;

endpackage

//--- src/spi_fsm.sv
`timescale 1ns/1ns

module spi_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic cpol,
    input  logic cpha,
    input  logic count_done,

    output logic busy,
    output logic load_en,
    output logic start_count,
    output logic start_clk,
    output logic shift_en_posedge,
    output logic shift_en_negedge,
    output logic sample_en_posedge,
    output logic sample_en_negedge,
    output logic done
);

    import spi_fsm_pkg::*;
    import spi_mode_pkg::*;

    spi_state_t state;
    spi_state_t state_nxt;
    spi_mode_t  mode;

    assign mode = spi_mode_t'({cpol, cpha});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = LOAD;
                end
            end
            LOAD: begin
                state_nxt = TRANSFER;
            end
            TRANSFER: begin
                if (count_done) begin
                    state_nxt = FINISH;
                end
            end
            FINISH: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_comb begin
        busy              = 1'b0;
        load_en           = 1'b0;
        start_count       = 1'b0;
        start_clk         = 1'b0;
        shift_en_posedge  = 1'b0;
        shift_en_negedge  = 1'b0;
        sample_en_posedge = 1'b0;
        sample_en_negedge = 1'b0;
        done              = 1'b0;

        case (state)
            LOAD: begin
                busy    = 1'b1;
                load_en = 1'b1; // Word goes into shift register
            end
            TRANSFER: begin
                busy        = 1'b1;
                start_count = 1'b1;
                start_clk   = 1'b1;
                case (mode)
                    MODE0, MODE3: begin
                        shift_en_negedge  = 1'b1; // Data changes on fall
                        sample_en_posedge = 1'b1;
                    end
                    default: begin
                        shift_en_posedge  = 1'b1; // Modes 1 and 2
                        sample_en_negedge = 1'b1;
                    end
                endcase
            end
            FINISH: begin
                busy = 1'b1;
                done = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- src/spi_clk_gen.sv
`timescale 1ns/1ns

module spi_clk_gen #(
    parameter int CLK_DIV = spi_mode_pkg::DEFAULT_CLK_DIV
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start_clk,
    input  logic cpol,

    output logic sclk,
    output logic sclk_rise,
    output logic sclk_fall
);

    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CW-1:0] div_cnt;
    logic          phase;  // Set while sclk is away from idle level
    logic          toggle;
    logic          sclk_nxt;

    assign toggle   = start_clk && (div_cnt == CW'(CLK_DIV - 1));
    assign sclk_nxt = ~phase ^ cpol;

    // Held at cpol whenever phase is clear
    assign sclk = phase ^ cpol;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            phase     <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end else if (!start_clk) begin
            div_cnt   <= '0;
            phase     <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end else begin
            sclk_rise <= toggle && sclk_nxt;  // Same cycle as new sclk level
            sclk_fall <= toggle && !sclk_nxt;
            if (toggle) begin
                div_cnt <= '0;
                phase   <= ~phase;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- src/spi_edge_counter.sv
`timescale 1ns/1ns

module spi_edge_counter #(
    parameter int DATA_WIDTH = spi_mode_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start_count,
    input  logic sclk_rise,
    input  logic sclk_fall,

    output logic count_done
);

    localparam int EDGES = 2 * DATA_WIDTH;
    localparam int CW    = $clog2(EDGES + 1);

    logic [CW-1:0] edge_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_cnt <= '0;
        end else if (!start_count) begin
            edge_cnt <= '0;
        end else if ((sclk_rise || sclk_fall) && !count_done) begin
            edge_cnt <= edge_cnt + 1'b1;
        end
    end

    // Stays high until the sequencer drops start_count
    assign count_done = (edge_cnt == CW'(EDGES));

endmodule

//--- src/spi_shift_reg.sv
`timescale 1ns/1ns

module spi_shift_reg #(
    parameter int DATA_WIDTH = spi_mode_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_en,
    input  logic                  done,
    input  logic [DATA_WIDTH-1:0] tx_data,
    input  logic                  shift_en_posedge,
    input  logic                  shift_en_negedge,
    input  logic                  sample_en_posedge,
    input  logic                  sample_en_negedge,
    input  logic                  sclk_rise,
    input  logic                  sclk_fall,
    input  logic                  cpha,
    input  logic                  miso,

    output logic                  mosi,
    output logic [DATA_WIDTH-1:0] rx_data
);

    logic [DATA_WIDTH-1:0] shift_q;
    logic [DATA_WIDTH-1:0] rx_hold;
    logic [DATA_WIDTH-1:0] rx_word;
    logic                  sample_q;
    logic                  first_edge;
    logic                  shift_fire;
    logic                  sample_fire;

    assign shift_fire  = (shift_en_posedge && sclk_rise) || (shift_en_negedge && sclk_fall);
    assign sample_fire = (sample_en_posedge && sclk_rise) || (sample_en_negedge && sclk_fall);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q    <= '0;
            first_edge <= 1'b0;
        end else if (load_en) begin
            shift_q    <= tx_data;
            first_edge <= 1'b1;
        end else if (shift_fire) begin
            first_edge <= 1'b0;
            if (!(cpha && first_edge)) begin  // Leading edge keeps the MSB
                shift_q <= {shift_q[DATA_WIDTH-2:0], sample_q};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_fire) begin
            sample_q <= miso;
        end
    end

    // With cpha set the last sample has no shift after it
    assign rx_word = cpha ? {shift_q[DATA_WIDTH-2:0], sample_q} : shift_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_hold <= '0;
        end else if (done) begin
            rx_hold <= rx_word;
        end
    end

    assign rx_data = done ? rx_word : rx_hold;  // Valid during the done pulse
    assign mosi    = shift_q[DATA_WIDTH-1];

endmodule

//--- src/spi_master.sv
`timescale 1ns/1ns

module spi_master #(
    parameter int DATA_WIDTH = spi_mode_pkg::DEFAULT_DATA_WIDTH,
    parameter int CLK_DIV    = spi_mode_pkg::DEFAULT_CLK_DIV  // Keep at 3 or more
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [DATA_WIDTH-1:0] tx_data,
    input  logic                  cpol,
    input  logic                  cpha,
    input  logic                  miso,

    output logic                  sclk,
    output logic                  mosi,
    output logic                  cs_n,
    output logic                  busy,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid
);

    logic load_en;
    logic start_count;
    logic start_clk;
    logic count_done;
    logic done;
    logic sclk_rise;
    logic sclk_fall;
    logic shift_en_posedge;
    logic shift_en_negedge;
    logic sample_en_posedge;
    logic sample_en_negedge;

    spi_fsm u_fsm (
        .clk, .rst_n, .start, .cpol, .cpha, .count_done,
        .busy, .load_en, .start_count, .start_clk,
        .shift_en_posedge, .shift_en_negedge,
        .sample_en_posedge, .sample_en_negedge, .done
    );

    spi_clk_gen #(.CLK_DIV(CLK_DIV)) u_clk_gen (
        .clk, .rst_n, .start_clk, .cpol,
        .sclk, .sclk_rise, .sclk_fall
    );

    spi_edge_counter #(.DATA_WIDTH(DATA_WIDTH)) u_edge_counter (
        .clk, .rst_n, .start_count, .sclk_rise, .sclk_fall, .count_done
    );

    spi_shift_reg #(.DATA_WIDTH(DATA_WIDTH)) u_shift_reg (
        .clk, .rst_n, .load_en, .done, .tx_data,
        .shift_en_posedge, .shift_en_negedge,
        .sample_en_posedge, .sample_en_negedge,
        .sclk_rise, .sclk_fall, .cpha, .miso,
        .mosi, .rx_data
    );

    assign cs_n     = ~busy;  // Single slave select
    assign rx_valid = done;

endmodule

//--- dv/spi_master_chk.sv
`timescale 1ns/1ns

module spi_master_chk #(
    parameter int DATA_WIDTH = spi_mode_pkg::DEFAULT_DATA_WIDTH
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    cs_n,
    input logic                    sclk,
    input logic                    cpol,
    input logic                    busy,
    input logic                    rx_valid,
    input spi_fsm_pkg::spi_state_t fsm_state
);

    import spi_fsm_pkg::*;

    int   fail_cnt = 0;
    int   edge_cnt;
    logic sclk_q;

    // sclk transitions inside one cs_n low window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_cnt <= 0;
            sclk_q   <= 1'b0;
        end else begin
            sclk_q <= sclk;
            if (cs_n) begin
                edge_cnt <= 0;
            end else if (sclk != sclk_q) begin
                edge_cnt <= edge_cnt + 1;
            end
        end
    end

    idle_level: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> sclk == cpol)
        else begin
            $error("sclk is away from its idle level while cs_n is high");
            fail_cnt++;
        end

    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
        else begin
            $error("rx_valid stayed high for more than one cycle");
            fail_cnt++;
        end

    busy_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(rx_valid) && $past(fsm_state) == FINISH)
        else begin
            $error("busy dropped without a preceding rx_valid");
            fail_cnt++;
        end

    edge_total: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cs_n) |-> edge_cnt == 2 * DATA_WIDTH)
        else begin
            $error("Wrong number of sclk edges in a cs_n window: %0d", edge_cnt);
            fail_cnt++;
        end

endmodule

bind spi_master spi_master_chk #(.DATA_WIDTH(DATA_WIDTH)) u_chk (
    .clk, .rst_n, .cs_n, .sclk, .cpol, .busy, .rx_valid,
    .fsm_state(u_fsm.state)
);

//--- dv/spi_master_tb.sv
`timescale 1ns/1ns

module spi_master_tb;

    import spi_mode_pkg::*;

    localparam int DATA_WIDTH = DEFAULT_DATA_WIDTH;
    localparam int CLK_DIV    = DEFAULT_CLK_DIV;
    localparam int NUM_TESTS  = 14;  // Reset, four modes, busy start, eight random
    localparam int MAX_CYCLES = NUM_TESTS * (2 * DATA_WIDTH * CLK_DIV + 10) + 3;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  cpol;
    logic                  cpha;
    logic                  miso;
    logic                  sclk;
    logic                  mosi;
    logic                  cs_n;
    logic                  busy;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  rx_valid;

    logic [31:0]           lfsr = 32'h50ad4697;
    logic [DATA_WIDTH-1:0] slave_tx;
    logic [DATA_WIDTH-1:0] slave_rx;
    int                    tx_ptr;
    logic                  sclk_q = 1'b0;
    logic                  cs_q = 1'b1;
    int                    cycles = 0;
    int                    n_pass = 0;
    int                    n_fail = 0;

    spi_master #(.DATA_WIDTH(DATA_WIDTH), .CLK_DIV(CLK_DIV)) dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a transfer never finished", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Slave model sampling sclk and cs_n on the falling clk edge
    always @(negedge clk) begin
        if (!cs_n && cs_q) begin
            slave_tx = DATA_WIDTH'(lfsr_bits(DATA_WIDTH));
            slave_rx = '0;
            tx_ptr   = cpha ? DATA_WIDTH - 1 : DATA_WIDTH - 2;
            if (!cpha) begin
                miso <= slave_tx[DATA_WIDTH-1];  // MSB ready before first edge
            end
        end else if (!cs_n && sclk != sclk_q) begin
            if ((sclk != cpol) != cpha) begin
                slave_rx = {slave_rx[DATA_WIDTH-2:0], mosi};
            end else if (tx_ptr >= 0) begin
                miso <= slave_tx[tx_ptr];
                tx_ptr--;
            end
        end
        cs_q   = cs_n;
        sclk_q = sclk;
    end

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            n_pass++;
            $display("%s: pass", name);
        end else begin
            n_fail++;
            $display("%s: FAIL", name);
        end
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual, inout bit ok);
        assert (actual === expected) else begin
            $display("Error %s %s expected %h actual %h", name, what, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        assert (cs_n === 1'b1 && busy === 1'b0 && rx_valid === 1'b0 && mosi === 1'b0
                && sclk === cpol) else begin
            $display("Bus not idle after reset: cs_n %b busy %b rx_valid %b mosi %b sclk %b",
                     cs_n, busy, rx_valid, mosi, sclk);
            ok = 1'b0;
        end
        cpol = 1'b1;
        @(negedge clk);
        assert (sclk === 1'b1) else begin
            $display("sclk did not follow cpol while idle");
            ok = 1'b0;
        end
        report_test("reset", ok);
    endtask

    // Called on a falling edge, returns on the falling edge after rx_valid
    task automatic run_transfer(input string name, input spi_mode_t mode,
                                input logic [DATA_WIDTH-1:0] word);
        bit ok;
        ok = 1'b1;
        {cpol, cpha} = mode;
        tx_data = word;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!rx_valid) @(negedge clk);
        check_word(name, "slave mosi word", word, slave_rx, ok);
        check_word(name, "rx_data", slave_tx, rx_data, ok);
        @(negedge clk);
        check_word(name, "held rx_data", slave_tx, rx_data, ok);
        report_test(name, ok);
    endtask

    task automatic check_busy_start();
        logic [DATA_WIDTH-1:0] first_word;
        bit                    ok;
        ok         = 1'b1;
        first_word = DATA_WIDTH'(32'hC3);
        {cpol, cpha} = MODE0;
        tx_data = first_word;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (CLK_DIV) @(negedge clk);
        assert (busy) else begin
            $display("DUT was not busy when the second start was pulsed");
            ok = 1'b0;
        end
        tx_data = ~first_word;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!rx_valid) @(negedge clk);
        check_word("busy_start", "slave mosi word", first_word, slave_rx, ok);
        check_word("busy_start", "rx_data", slave_tx, rx_data, ok);
        repeat (4) begin
            @(negedge clk);
            assert (!busy && !rx_valid) else begin
                $display("A start pulsed while busy began a second transfer");
                ok = 1'b0;
            end
        end
        report_test("busy_start", ok);
    endtask

    initial begin
        int                    i;
        logic [1:0]            mode_bits;
        logic [DATA_WIDTH-1:0] word;
        rst_n   = 1'b0;
        start   = 1'b0;
        tx_data = '0;
        cpol    = 1'b0;
        cpha    = 1'b0;
        miso    = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_reset();
        run_transfer("mode0", MODE0, DATA_WIDTH'(32'hA5));
        run_transfer("mode1", MODE1, DATA_WIDTH'(32'h3C));
        run_transfer("mode2", MODE2, DATA_WIDTH'(32'h96));
        run_transfer("mode3", MODE3, DATA_WIDTH'(32'h5A));
        check_busy_start();
        for (i = 0; i < 8; i++) begin
            mode_bits = 2'(lfsr_bits(2));
            word      = DATA_WIDTH'(lfsr_bits(DATA_WIDTH));
            run_transfer($sformatf("random%0d", i), spi_mode_t'(mode_bits), word);
        end
        $display("Tests passed %0d, failed %0d, assertion failures %0d",
                 n_pass, n_fail, dut.u_chk.fail_cnt);
        if (n_fail == 0 && dut.u_chk.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- files.f
src/spi_mode_pkg.sv
src/spi_fsm_pkg.sv
src/spi_fsm.sv
src/spi_clk_gen.sv
src/spi_edge_counter.sv
src/spi_shift_reg.sv
src/spi_master.sv
dv/spi_master_chk.sv
dv/spi_master_tb.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - src/spi_mode_pkg.sv
  - src/spi_fsm_pkg.sv
  - src/spi_fsm.sv
  - src/spi_clk_gen.sv
  - src/spi_edge_counter.sv
  - src/spi_shift_reg.sv
  - src/spi_master.sv
  - target: test
    files:
      - dv/spi_master_chk.sv
      - dv/spi_master_tb.sv
